// ==== cachePkg.sv ====
package cachePkg;

  // request address and data word widths
  localparam int AddrWidth = 32;
  localparam int XLen = 64;

  // 32-byte lines, four words each
  localparam int OffsetWidth = 5;
  localparam int LineWidth = 8 << OffsetWidth;

  // two ways, fixed by the tag array and the SRAM wiring
  localparam int NumWays = 2;

  typedef logic [XLen-1:0] wordT;
  typedef logic [LineWidth-1:0] lineT;

  // controller states
  typedef enum logic [2:0] {
    CacheIdle,
    CacheCompare,
    CacheMiss,
    CacheRefill,
    CacheReplay
  } cacheStateE;

endpackage

// ==== axiPkg.sv ====
package axiPkg;

  // AXI4-Lite read port widths
  localparam int AxiAddrWidth = 32;
  localparam int AxiDataWidth = 64;

  // single-beat reads per cache line
  localparam int BeatsPerLine = 4;

  typedef enum logic [1:0] {
    RespOkay   = 2'b00,
    RespExOkay = 2'b01,
    RespSlvErr = 2'b10,
    RespDecErr = 2'b11
  } axiRespE;

  // refill master states
  typedef enum logic [1:0] {
    RefIdle,
    RefAddr,
    RefData,
    RefDone
  } refillStateE;

endpackage

// ==== cacheSram.sv ====
`timescale 1ns/100ps

module cacheSram
  import cachePkg::*;
#(
  parameter int NumSets = 64
) (
  input  logic                       clk,
  input  logic                       en_i,
  input  logic                       we_i,
  input  logic [$clog2(NumSets)-1:0] addr_i,
  input  logic [2*XLen-1:0]          wdata_i,
  output logic [2*XLen-1:0]          rdata_o
);

  // one 128-bit half of a way's lines
  logic [2*XLen-1:0] mem [NumSets];

  // single port, read data one cycle after an enabled read
  always_ff @(posedge clk) begin
    if (en_i) begin
      if (we_i) begin
        mem[addr_i] <= wdata_i;
      end else begin
        rdata_o <= mem[addr_i];
      end
    end
  end

endmodule

// ==== cacheTagArray.sv ====
`timescale 1ns/100ps

module cacheTagArray
  import cachePkg::*;
#(
  parameter int NumSets = 64
) (
  input  logic                                              clk,
  input  logic                                              rst_n,
  input  logic [$clog2(NumSets)-1:0]                        index_i,
  input  logic [AddrWidth-$clog2(NumSets)-OffsetWidth-1:0]  tag_i,
  input  logic                                              tagWrite_i,
  input  logic                                              writeWay_i,
  input  logic                                              lruTouch_i,
  input  logic                                              lruWay_i,
  output logic                                              way0Hit_o,
  output logic                                              way1Hit_o,
  output logic                                              victimWay_o
);

  localparam int TagWidth = AddrWidth - $clog2(NumSets) - OffsetWidth;

  logic [TagWidth-1:0] tagMem [NumWays][NumSets];
  logic [NumSets-1:0]  validQ [NumWays];
  // one bit per set, names the least recently used way
  logic [NumSets-1:0]  lruQ;

  always_ff @(posedge clk) begin
    if (tagWrite_i) begin
      tagMem[writeWay_i][index_i] <= tag_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int w = 0; w < NumWays; w++) begin
        validQ[w] <= '0;
      end
    end else if (tagWrite_i) begin
      validQ[writeWay_i][index_i] <= 1'b1;
    end
  end

  // a hit makes the other way the next victim
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lruQ <= '0;
    end else if (lruTouch_i) begin
      lruQ[index_i] <= ~lruWay_i;
    end
  end

  assign way0Hit_o = validQ[0][index_i] && (tagMem[0][index_i] == tag_i);
  assign way1Hit_o = validQ[1][index_i] && (tagMem[1][index_i] == tag_i);
  assign victimWay_o = lruQ[index_i];

  // a line is only ever installed in one way
  assert property (@(posedge clk) disable iff (!rst_n)
    !(way0Hit_o && way1Hit_o));

endmodule

// ==== cacheCtrl.sv ====
`timescale 1ns/100ps

module cacheCtrl
  import cachePkg::*;
#(
  parameter int NumSets = 64
) (
  input  logic                                              clk,
  input  logic                                              rst_n,
  input  logic                                              reqValid_i,
  input  logic [AddrWidth-1:0]                              reqAddr_i,
  output logic                                              addrOk_o,
  output logic                                              dataOk_o,
  output logic                                              dataErr_o,
  output wordT                                              rdData_o,
  output logic [$clog2(NumSets)-1:0]                        tagIndex_o,
  output logic [AddrWidth-$clog2(NumSets)-OffsetWidth-1:0]  tag_o,
  output logic [$clog2(NumSets)-1:0]                        sramAddr_o,
  input  logic                                              way0Hit_i,
  input  logic                                              way1Hit_i,
  input  logic                                              victimWay_i,
  output logic                                              tagWrite_o,
  output logic                                              lruTouch_o,
  output logic                                              lruWay_o,
  output logic [2*NumWays-1:0]                              sramEn_o,
  output logic [2*NumWays-1:0]                              sramWe_o,
  input  logic [2*NumWays-1:0][2*XLen-1:0]                  sramRdata_i,
  output lineT                                              sramWdata_o,
  output logic                                              refillStart_o,
  output logic [AddrWidth-1:0]                              refillAddr_o,
  input  logic                                              refillDone_i,
  input  lineT                                              refillLine_i,
  input  logic                                              refillErr_i
);

  localparam int IndexWidth = $clog2(NumSets);
  localparam int TagWidth = AddrWidth - IndexWidth - OffsetWidth;

  cacheStateE           state;
  cacheStateE           nextState;
  logic [AddrWidth-1:0] reqQ;
  logic                 errExit;
  logic                 hit;
  logic                 accept;
  logic                 installLine;
  logic                 sramRead;
  logic [1:0]           wordSel;
  lineT                 hitLine;

  assign hit = way0Hit_i || way1Hit_i;
  // error exit cycle takes no new request
  assign addrOk_o = ((state == CacheIdle) && !errExit) || ((state == CacheCompare) && hit);
  assign accept = reqValid_i && addrOk_o;

  always_comb begin
    nextState = state;
    unique case (state)
      CacheIdle: begin
        if (accept) begin
          nextState = CacheCompare;
        end
      end
      CacheCompare: begin
        if (!hit) begin
          nextState = CacheMiss;
        end else if (!accept) begin
          nextState = CacheIdle;
        end
      end
      CacheMiss: begin
        nextState = CacheRefill;
      end
      CacheRefill: begin
        if (refillDone_i) begin
          nextState = refillErr_i ? CacheIdle : CacheReplay;
        end
      end
      CacheReplay: begin
        nextState = CacheCompare;
      end
      default: begin
        nextState = CacheIdle;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= CacheIdle;
      reqQ <= '0;
      errExit <= 1'b0;
    end else begin
      state <= nextState;
      errExit <= (state == CacheRefill) && refillDone_i && refillErr_i;
      if (accept) begin
        reqQ <= reqAddr_i;
      end
    end
  end

  // tags compare on the held request while the SRAM looks ahead on accept
  assign tagIndex_o = reqQ[OffsetWidth +: IndexWidth];
  assign tag_o = reqQ[AddrWidth-1 -: TagWidth];
  assign sramAddr_o = accept ? reqAddr_i[OffsetWidth +: IndexWidth] : tagIndex_o;

  assign dataOk_o = ((state == CacheCompare) && hit) || errExit;
  assign dataErr_o = errExit;
  assign lruTouch_o = (state == CacheCompare) && hit;
  assign lruWay_o = way1Hit_i;

  // install only a line that came back clean
  assign installLine = (state == CacheRefill) && refillDone_i && !refillErr_i;
  assign tagWrite_o = installLine;
  assign sramWdata_o = refillLine_i;
  assign refillStart_o = (state == CacheMiss);
  assign refillAddr_o = {reqQ[AddrWidth-1:OffsetWidth], {OffsetWidth{1'b0}}};

  assign sramRead = accept || (state == CacheReplay);

  // halves are ordered low then high with way 0 first
  always_comb begin
    for (int h = 0; h < 2 * NumWays; h++) begin
      sramWe_o[h] = installLine && (victimWay_i == 1'(h / 2));
      sramEn_o[h] = sramRead || sramWe_o[h];
    end
  end

  assign hitLine = way1Hit_i ? {sramRdata_i[3], sramRdata_i[2]}
                             : {sramRdata_i[1], sramRdata_i[0]};
  assign wordSel = reqQ[4:3];
  assign rdData_o = hitLine[wordSel*XLen +: XLen];

  // data outside Compare only on the error exit into Idle
  assert property (@(posedge clk) disable iff (!rst_n)
    (dataOk_o && (state != CacheCompare)) |-> ((state == CacheIdle) && dataErr_o));

endmodule

// ==== cacheRefill.sv ====
`timescale 1ns/100ps

module cacheRefill
  import axiPkg::*;
  import cachePkg::*;
(
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    refillStart_i,
  input  logic [AddrWidth-1:0]    refillAddr_i,
  output logic                    refillDone_o,
  output lineT                    refillLine_o,
  output logic                    refillErr_o,
  output logic                    arValid_o,
  input  logic                    arReady_i,
  output logic [AxiAddrWidth-1:0] arAddr_o,
  input  logic                    rValid_i,
  input  logic [AxiDataWidth-1:0] rData_i,
  input  axiRespE                 rResp_i,
  output logic                    rReady_o
);

  localparam int BeatCntWidth = $clog2(BeatsPerLine);
  localparam int BeatBytes = AxiDataWidth / 8;

  refillStateE             state;
  logic [BeatCntWidth-1:0] beatCnt;
  logic                    errQ;
  logic [AxiAddrWidth-1:0] arAddrQ;
  lineT                    lineQ;
  logic                    beatTaken;
  logic                    lastBeat;

  assign beatTaken = (state == RefData) && rValid_i;
  assign lastBeat = (beatCnt == BeatCntWidth'(BeatsPerLine - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= RefIdle;
      beatCnt <= '0;
      errQ <= 1'b0;
    end else begin
      unique case (state)
        RefIdle: begin
          if (refillStart_i) begin
            state <= RefAddr;
            beatCnt <= '0;
            errQ <= 1'b0;
          end
        end
        RefAddr: begin
          if (arReady_i) begin
            state <= RefData;
          end
        end
        RefData: begin
          if (rValid_i) begin
            // any non-Okay beat spoils the whole line
            errQ <= errQ || (rResp_i != RespOkay);
            if (lastBeat) begin
              state <= RefDone;
            end else begin
              beatCnt <= beatCnt + 1'b1;
              state <= RefAddr;
            end
          end
        end
        RefDone: begin
          state <= RefIdle;
        end
        default: begin
          state <= RefIdle;
        end
      endcase
    end
  end

  // beats shift in from the top, first beat ends in the low word
  always_ff @(posedge clk) begin
    if ((state == RefIdle) && refillStart_i) begin
      arAddrQ <= refillAddr_i;
    end else if (beatTaken) begin
      arAddrQ <= arAddrQ + AxiAddrWidth'(BeatBytes);
      lineQ <= {rData_i, lineQ[$bits(lineT)-1:AxiDataWidth]};
    end
  end

  assign arValid_o = (state == RefAddr);
  assign arAddr_o = arAddrQ;
  assign rReady_o = (state == RefData);
  assign refillDone_o = (state == RefDone);
  assign refillLine_o = lineQ;
  assign refillErr_o = errQ;

  // address holds until the slave takes it
  assert property (@(posedge clk) disable iff (!rst_n)
    (arValid_o && !arReady_i) |=> (arValid_o && $stable(arAddr_o)));

endmodule

// ==== icacheTop.sv ====
`timescale 1ns/100ps

module icacheTop
  import cachePkg::*;
  import axiPkg::*;
#(
  parameter int NumSets = 64
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    reqValid_i,
  input  logic [AddrWidth-1:0]    reqAddr_i,
  output logic                    addrOk_o,
  output logic                    dataOk_o,
  output logic                    dataErr_o,
  output wordT                    rdData_o,
  output logic                    arValid_o,
  input  logic                    arReady_i,
  output logic [AxiAddrWidth-1:0] arAddr_o,
  input  logic                    rValid_i,
  input  logic [AxiDataWidth-1:0] rData_i,
  input  axiRespE                 rResp_i,
  output logic                    rReady_o
);

  localparam int IndexWidth = $clog2(NumSets);
  localparam int TagWidth = AddrWidth - IndexWidth - OffsetWidth;

  logic [IndexWidth-1:0]                 tagIndex;
  logic [TagWidth-1:0]                   lookupTag;
  logic [IndexWidth-1:0]                 sramAddr;
  logic                                  way0Hit;
  logic                                  way1Hit;
  logic                                  victimWay;
  logic                                  tagWrite;
  logic                                  lruTouch;
  logic                                  lruWay;
  logic [2*NumWays-1:0]                  sramEn;
  logic [2*NumWays-1:0]                  sramWe;
  logic [2*NumWays-1:0][2*XLen-1:0]      sramRdata;
  lineT                                  sramWdata;
  logic                                  refillStart;
  logic [AddrWidth-1:0]                  refillAddr;
  logic                                  refillDone;
  lineT                                  refillLine;
  logic                                  refillErr;

  cacheCtrl #(
    .NumSets(NumSets)
  ) uCtrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .reqValid_i   (reqValid_i),
    .reqAddr_i    (reqAddr_i),
    .addrOk_o     (addrOk_o),
    .dataOk_o     (dataOk_o),
    .dataErr_o    (dataErr_o),
    .rdData_o     (rdData_o),
    .tagIndex_o   (tagIndex),
    .tag_o        (lookupTag),
    .sramAddr_o   (sramAddr),
    .way0Hit_i    (way0Hit),
    .way1Hit_i    (way1Hit),
    .victimWay_i  (victimWay),
    .tagWrite_o   (tagWrite),
    .lruTouch_o   (lruTouch),
    .lruWay_o     (lruWay),
    .sramEn_o     (sramEn),
    .sramWe_o     (sramWe),
    .sramRdata_i  (sramRdata),
    .sramWdata_o  (sramWdata),
    .refillStart_o(refillStart),
    .refillAddr_o (refillAddr),
    .refillDone_i (refillDone),
    .refillLine_i (refillLine),
    .refillErr_i  (refillErr)
  );

  // the victim way is also the install way
  cacheTagArray #(
    .NumSets(NumSets)
  ) uTags (
    .clk        (clk),
    .rst_n      (rst_n),
    .index_i    (tagIndex),
    .tag_i      (lookupTag),
    .tagWrite_i (tagWrite),
    .writeWay_i (victimWay),
    .lruTouch_i (lruTouch),
    .lruWay_i   (lruWay),
    .way0Hit_o  (way0Hit),
    .way1Hit_o  (way1Hit),
    .victimWay_o(victimWay)
  );

  // instance h holds half h%2 of way h/2
  for (genvar h = 0; h < 2 * NumWays; h++) begin : gSram
    cacheSram #(
      .NumSets(NumSets)
    ) uSram (
      .clk    (clk),
      .en_i   (sramEn[h]),
      .we_i   (sramWe[h]),
      .addr_i (sramAddr),
      .wdata_i(sramWdata[(h % 2)*2*XLen +: 2*XLen]),
      .rdata_o(sramRdata[h])
    );
  end

  cacheRefill uRefill (
    .clk          (clk),
    .rst_n        (rst_n),
    .refillStart_i(refillStart),
    .refillAddr_i (refillAddr),
    .refillDone_o (refillDone),
    .refillLine_o (refillLine),
    .refillErr_o  (refillErr),
    .arValid_o    (arValid_o),
    .arReady_i    (arReady_i),
    .arAddr_o     (arAddr_o),
    .rValid_i     (rValid_i),
    .rData_i      (rData_i),
    .rResp_i      (rResp_i),
    .rReady_o     (rReady_o)
  );

endmodule

// ==== tbClock.sv ====
`timescale 1ns/100ps

module tbClock #(
  parameter int PeriodNs = 8,
  parameter int ResetCycles = 16
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever begin
      #(PeriodNs / 2);
      clk_o = ~clk_o;
    end
  end

  // reset leaves 1 ns after an edge, like every other input
  initial begin
    rst_n_o = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    #1;
    rst_n_o = 1'b1;
  end

endmodule

// ==== tbMemModel.sv ====
`timescale 1ns/100ps

module tbMemModel
  import axiPkg::*;
#(
  parameter logic [31:0] Seed = 32'h72db1ccf,
  parameter logic [31:0] ErrBase = 32'h0000_f000,
  parameter logic [31:0] ErrSize = 32'h0000_0100
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        arValid_i,
  output logic        arReady_o,
  input  logic [31:0] arAddr_i,
  output logic        rValid_o,
  output logic [63:0] rData_o,
  output axiRespE     rResp_o,
  input  logic        rReady_i
);

  logic [31:0] randState;
  logic [31:0] beatAddr;
  logic        pending;
  logic        arTaken;
  logic        rTaken;
  int          arWait;
  int          rWait;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // 0 to 3 stall cycles
  function automatic int nextStall();
    randState = xorshift32(randState);
    return int'(randState[1:0]);
  endfunction

  function automatic logic inErrWindow(input logic [31:0] addr);
    return (addr >= ErrBase) && (addr < ErrBase + ErrSize);
  endfunction

  initial begin
    arReady_o = 1'b0;
    rValid_o = 1'b0;
    rData_o = '0;
    rResp_o = RespOkay;
    randState = Seed;
    beatAddr = '0;
    pending = 1'b0;
    arTaken = 1'b0;
    rTaken = 1'b0;
    arWait = 0;
    rWait = 0;
    forever begin
      @(posedge clk);
      #1;
      if (!rst_n) begin
        arReady_o = 1'b0;
        rValid_o = 1'b0;
        pending = 1'b0;
        arTaken = 1'b0;
        rTaken = 1'b0;
      end else begin
        // handshakes that completed on the edge just passed
        if (arTaken) begin
          pending = 1'b1;
          rWait = nextStall();
        end
        if (rTaken) begin
          rValid_o = 1'b0;
          pending = 1'b0;
          arWait = nextStall();
        end
        // one read at a time, AR waits while a beat is owed
        arReady_o = 1'b0;
        if (arValid_i && !pending) begin
          if (arWait == 0) begin
            arReady_o = 1'b1;
          end else begin
            arWait--;
          end
        end
        if (pending && !rValid_o) begin
          if (rWait == 0) begin
            rValid_o = 1'b1;
            if (inErrWindow(beatAddr)) begin
              rData_o = '0;
              rResp_o = RespSlvErr;
            end else begin
              rData_o = {beatAddr, beatAddr};
              rResp_o = RespOkay;
            end
          end else begin
            rWait--;
          end
        end
        // levels now hold until the next edge
        arTaken = arValid_i && arReady_o;
        if (arTaken) begin
          beatAddr = arAddr_i;
        end
        rTaken = rValid_o && rReady_i;
      end
    end
  end

endmodule

// ==== icacheTb.sv ====
`timescale 1ns/100ps

module icacheTb
  import axiPkg::*;
();

  localparam int NumSets = 64;
  localparam int WaitLimit = 200;
  localparam logic [31:0] Seed = 32'h72db1ccf;
  localparam logic [31:0] ErrBase = 32'h0000_f000;
  localparam logic [31:0] LineA = 32'h0000_0040;
  localparam logic [31:0] LineB = 32'h0000_0100;
  localparam logic [31:0] RandBase = 32'h0000_4000;

  logic        clk;
  logic        rst_n;
  logic        reqValid;
  logic [31:0] reqAddr;
  logic        addrOk;
  logic        dataOk;
  logic        dataErr;
  logic [63:0] rdData;
  logic        arValid;
  logic        arReady;
  logic [31:0] arAddr;
  logic        rValid;
  logic [63:0] rData;
  axiRespE     rResp;
  logic        rReady;

  int          errors = 0;
  int          checkCount = 0;
  int          arCount = 0;
  logic [31:0] arLog [$];
  logic        timedOut = 1'b0;
  logic [31:0] randState;

  // reference model of line address and valid per way and LRU way per set
  logic [26:0] wayLine [NumSets][2];
  bit          wayValid [NumSets][2];
  bit          lruBit [NumSets];

  tbClock #(.PeriodNs(8), .ResetCycles(16)) uClock (.clk_o(clk), .rst_n_o(rst_n));

  icacheTop #(.NumSets(NumSets)) DUT (
    .clk(clk), .rst_n(rst_n), .reqValid_i(reqValid), .reqAddr_i(reqAddr),
    .addrOk_o(addrOk), .dataOk_o(dataOk), .dataErr_o(dataErr), .rdData_o(rdData),
    .arValid_o(arValid), .arReady_i(arReady), .arAddr_o(arAddr), .rValid_i(rValid),
    .rData_i(rData), .rResp_i(rResp), .rReady_o(rReady)
  );

  tbMemModel #(.Seed(Seed), .ErrBase(ErrBase), .ErrSize(32'h0000_0100)) uMem (
    .clk(clk), .rst_n(rst_n), .arValid_i(arValid), .arReady_o(arReady), .arAddr_i(arAddr),
    .rValid_o(rValid), .rData_o(rData), .rResp_o(rResp), .rReady_i(rReady)
  );

  // log every AR handshake and expect an offered beat to be awaited
  always @(negedge clk) begin
    if (rst_n && arValid && arReady) begin
      arCount++;
      arLog.push_back(arAddr);
    end
    if (rst_n && rValid) begin
      compareValue("rReady_o", 64'(rReady), 64'd1);
    end
  end

  initial begin
    wait (timedOut);
    $display("Test failed");
    $finish;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // memory word at A is the 8-byte aligned A twice
  function automatic logic [63:0] patternWord(input logic [31:0] addr);
    logic [31:0] beat;
    beat = {addr[31:3], 3'b000};
    return {beat, beat};
  endfunction

  // returns the predicted hit and updates tags and LRU as the cache would
  function automatic bit predictAccess(input logic [31:0] addr);
    logic [26:0] line;
    int          set;
    int          way;
    bit          hit;
    line = addr[31:5];
    set = int'(addr >> 5) % NumSets;
    hit = 1'b0;
    way = 0;
    for (int w = 0; w < 2; w++) begin
      if (wayValid[set][w] && (wayLine[set][w] == line)) begin
        hit = 1'b1;
        way = w;
      end
    end
    if (!hit) begin
      way = int'(lruBit[set]);
      wayValid[set][way] = 1'b1;
      wayLine[set][way] = line;
    end
    lruBit[set] = (way == 0);
    return hit;
  endfunction

  task automatic clearModel();
    for (int s = 0; s < NumSets; s++) begin
      wayValid[s][0] = 1'b0;
      wayValid[s][1] = 1'b0;
      lruBit[s] = 1'b0;
    end
  endtask

  task automatic compareValue(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
    checkCount++;
    assert (got === exp) else begin
      $display("CHECK FAILED at %0t: %s got %0h expected %0h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic requireTrue(input bit cond, input string what);
    checkCount++;
    assert (cond) else begin
      $display("error at %0t: %s", $time, what);
      errors++;
    end
  endtask

  task automatic flagTimeout(input string what);
    $display("timeout at %0t: %s", $time, what);
    timedOut = 1'b1;
  endtask

  task automatic printTestResult(input string name, input int errBefore);
    if (errors == errBefore) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: %0d errors", name, errors - errBefore);
    end
  endtask

  task automatic waitForReset();
    int waited;
    waited = 0;
    while (!rst_n && (waited < WaitLimit)) begin
      @(posedge clk);
      waited++;
    end
    if (!rst_n) begin
      flagTimeout("reset never released");
    end
  endtask

  // latency counts cycles from the accepting edge to dataOk_o
  task automatic issueRead(input logic [31:0] addr, output logic [63:0] data,
                           output logic err, output int latency);
    int waited;
    bit got;
    data = '0;
    err = 1'b0;
    latency = 0;
    got = 1'b0;
    @(posedge clk);
    #1;
    reqValid = 1'b1;
    reqAddr = addr;
    waited = 0;
    @(negedge clk);
    while (!addrOk && (waited < WaitLimit)) begin
      @(negedge clk);
      waited++;
    end
    if (!addrOk) begin
      flagTimeout("request never accepted");
      return;
    end
    @(posedge clk);
    #1;
    reqValid = 1'b0;
    while (!got && (latency < WaitLimit)) begin
      @(negedge clk);
      latency++;
      if (dataOk) begin
        got = 1'b1;
        data = rdData;
        err = dataErr;
      end
    end
    if (!got) begin
      flagTimeout("dataOk_o never arrived");
    end
  endtask

  // a miss fetches the line in four AR reads and a hit takes none
  task automatic readAndVerify(input logic [31:0] addr, input bit expectErr,
                               output bit arSeen);
    bit          predictHit;
    logic [63:0] data;
    logic        err;
    int          latency;
    int          arBefore;
    logic [31:0] lineBase;
    predictHit = 1'b0;
    if (!expectErr) begin
      predictHit = predictAccess(addr);
    end
    lineBase = {addr[31:5], 5'b00000};
    arBefore = arCount;
    arLog.delete();
    issueRead(addr, data, err, latency);
    arSeen = (arCount != arBefore);
    compareValue("dataErr_o", 64'(err), 64'(expectErr));
    if (!expectErr) begin
      compareValue("rdData_o", data, patternWord(addr));
    end
    if (predictHit) begin
      compareValue("hit latency", 64'(latency), 64'd1);
      compareValue("AR handshakes on hit", 64'(arCount - arBefore), 64'd0);
    end else begin
      compareValue("AR handshakes on miss", 64'(arCount - arBefore), 64'(BeatsPerLine));
    end
    // refill reads walk the line 8 bytes at a time
    for (int i = 0; i < arLog.size(); i++) begin
      compareValue("arAddr_o", 64'(arLog[i]), 64'(lineBase + 32'(8 * i)));
    end
  endtask

  task automatic coldMissThenHit();
    bit arSeen;
    readAndVerify(LineA, 1'b0, arSeen);
    requireTrue(arSeen, "cold read fetched nothing");
    readAndVerify(LineA, 1'b0, arSeen);
    requireTrue(!arSeen, "repeated read went to memory");
  endtask

  task automatic wholeLineWords();
    bit arSeen;
    int arBefore;
    arBefore = arCount;
    for (int w = 0; w < 4; w++) begin
      readAndVerify(LineB + 32'(8 * w), 1'b0, arSeen);
    end
    compareValue("AR handshakes for one line", 64'(arCount - arBefore), 64'd4);
  endtask

  task automatic backToBackHits();
    logic [31:0] addrs [4];
    int          issued;
    int          received;
    int          cycles;
    int          arBefore;
    bit          accepted;
    addrs[0] = LineB + 32'd24;
    addrs[1] = LineA;
    addrs[2] = LineB;
    addrs[3] = LineB + 32'd8;
    // keep the model's LRU in step with these hits
    for (int i = 0; i < 4; i++) begin
      void'(predictAccess(addrs[i]));
    end
    arBefore = arCount;
    issued = 0;
    received = 0;
    cycles = 0;
    @(posedge clk);
    #1;
    reqValid = 1'b1;
    reqAddr = addrs[0];
    while ((received < 4) && !timedOut) begin
      @(negedge clk);
      // one word per cycle once the first request is in
      if (cycles > 0) begin
        requireTrue(dataOk, "dataOk_o missing during back-to-back hits");
      end
      if (dataOk) begin
        compareValue("rdData_o", rdData, patternWord(addrs[received]));
        compareValue("dataErr_o", 64'(dataErr), 64'd0);
        received++;
      end
      if (reqValid) begin
        requireTrue(addrOk, "addrOk_o dropped during back-to-back hits");
      end
      accepted = reqValid && addrOk;
      cycles++;
      if (cycles >= WaitLimit) begin
        flagTimeout("back-to-back hits never finished");
      end
      @(posedge clk);
      #1;
      if (accepted) begin
        issued++;
        if (issued < 4) begin
          reqAddr = addrs[issued];
        end else begin
          reqValid = 1'b0;
        end
      end
    end
    compareValue("AR handshakes in back-to-back hits", 64'(arCount - arBefore), 64'd0);
  endtask

  // three tags in set 20
  task automatic lruReplacement();
    bit arSeen;
    readAndVerify(32'h0000_0280, 1'b0, arSeen);
    readAndVerify(32'h0000_0a80, 1'b0, arSeen);
    readAndVerify(32'h0000_0280, 1'b0, arSeen);
    readAndVerify(32'h0000_1280, 1'b0, arSeen);
    readAndVerify(32'h0000_0280, 1'b0, arSeen);
    requireTrue(!arSeen, "recently used tag A was evicted");
    readAndVerify(32'h0000_0a80, 1'b0, arSeen);
    requireTrue(arSeen, "least recently used tag B still hit");
  endtask

  task automatic errorResponse();
    bit arSeen;
    readAndVerify(ErrBase + 32'h8, 1'b1, arSeen);
    requireTrue(arSeen, "error read fetched nothing");
    readAndVerify(ErrBase + 32'h8, 1'b1, arSeen);
    requireTrue(arSeen, "line with error response was installed");
  endtask

  task automatic randomReads();
    logic [31:0] addr;
    bit          arSeen;
    for (int i = 0; i < 200; i++) begin
      randState = xorshift32(randState);
      // random tag bits 13:11 with sets 0 to 3 and words 0 to 3
      addr = RandBase | {18'b0, randState[2:0], 4'b0, randState[4:3], randState[6:5], 3'b000};
      readAndVerify(addr, 1'b0, arSeen);
    end
  endtask

  initial begin
    int startErr;
    reqValid = 1'b0;
    reqAddr = '0;
    randState = Seed;
    clearModel();
    waitForReset();
    startErr = errors;
    coldMissThenHit();
    printTestResult("cold miss then hit", startErr);
    startErr = errors;
    wholeLineWords();
    printTestResult("all four words of a line", startErr);
    startErr = errors;
    backToBackHits();
    printTestResult("back-to-back hits", startErr);
    startErr = errors;
    lruReplacement();
    printTestResult("LRU replacement", startErr);
    startErr = errors;
    errorResponse();
    printTestResult("error response", startErr);
    startErr = errors;
    randomReads();
    printTestResult("random reads under stalls", startErr);
    @(posedge clk);
    $display("%0d checks, %0d errors", checkCount, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== icacheTop.f ====
cachePkg.sv
axiPkg.sv
cacheSram.sv
cacheTagArray.sv
cacheCtrl.sv
cacheRefill.sv
icacheTop.sv
tbClock.sv
tbMemModel.sv
icacheTb.sv

// ==== Makefile ====
SIM      := verilator
TOP      := icacheTb
FILELIST := icacheTop.f
FLAGS    := --binary --timing --assert
BUILDDIR := obj_dir

SOURCES := $(shell cat $(FILELIST))
BIN     := $(BUILDDIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -Mdir $(BUILDDIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Test completed successfully"

clean:
	rm -rf $(BUILDDIR)
